/* common/cab_defs.svh */
`ifndef CAB_DEFS_SVH
`define CAB_DEFS_SVH

// core audio sample
`define DAC_WIDTH 10

// core pixel is 3/3/2
`define CORE_RG_W 3
`define CORE_B_W 2

// board VGA resistor ladder
`define VGA_W 6

`endif

/* common/ctrl_pkg.sv */
package ctrl_pkg;

	typedef enum logic [7:0] {
		key_start1 = 8'h05, // F1
		key_start2 = 8'h06, // F2
		key_fire2  = 8'h11, // alt
		key_fire3  = 8'h14, // ctrl
		key_fire1  = 8'h29, // space
		key_left   = 8'h6b,
		key_down   = 8'h72,
		key_right  = 8'h74,
		key_up     = 8'h75,
		key_coin   = 8'h76  // esc
	} key_code_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic fire3;
	} held_keys_t;

	// bit 0 is right, bit 5 is bomb
	typedef struct packed {
		logic [1:0] unused;
		logic bomb;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

endpackage

/* common/video_pkg.sv */
`include "cab_defs.svh"

package video_pkg;

	typedef logic [`VGA_W-1:0] vga_color_t;

	// 3/3/2 pixel straight from the core
	typedef struct packed {
		logic [`CORE_RG_W-1:0] r;
		logic [`CORE_RG_W-1:0] g;
		logic [`CORE_B_W-1:0]  b;
	} core_rgb_t;

	typedef enum logic [1:0] {
		scan_off   = 2'd0,
		scan_dim25 = 2'd1,
		scan_dim50 = 2'd2,
		scan_dim75 = 2'd3
	} scan_mode_t;

endpackage

/* input/key_mapper.sv */
`timescale 1ns/1ps

module key_mapper import ctrl_pkg::*; (
	input  logic       clk_36,
	input  logic       rst,
	input  logic       key_toggle,
	input  logic       key_pressed,
	input  logic [7:0] key_code,
	output held_keys_t held_keys
);

	logic      toggle_q;
	logic      key_event;
	key_code_t code;

	assign key_event = key_toggle != toggle_q; // link flips toggle once per event
	assign code = key_code_t'(key_code);

	always_ff @(posedge clk_36) begin
		if (rst) begin
			toggle_q  <= 1'b0;
			held_keys <= '0;
		end else begin
			toggle_q <= key_toggle;
			if (key_event) begin
				case (code)
					key_up: begin
						held_keys.up <= key_pressed;
					end
					key_down: begin
						held_keys.down <= key_pressed;
					end
					key_left: begin
						held_keys.left <= key_pressed;
					end
					key_right: begin
						held_keys.right <= key_pressed;
					end
					key_coin: begin
						held_keys.coin <= key_pressed;
					end
					key_start1: begin
						held_keys.start1 <= key_pressed;
					end
					key_start2: begin
						held_keys.start2 <= key_pressed;
					end
					key_fire1: begin
						held_keys.fire1 <= key_pressed;
					end
					key_fire2: begin
						held_keys.fire2 <= key_pressed;
					end
					key_fire3: begin
						held_keys.fire3 <= key_pressed;
					end
					default: begin
						held_keys <= held_keys; // unmapped key
					end
				endcase
			end
		end
	end

endmodule

/* input/control_router.sv */
`timescale 1ns/1ps

module control_router import ctrl_pkg::*; (
	input  logic       clk_36,
	input  logic       rst,
	input  held_keys_t held_keys,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  logic       rotate_controls,
	output logic       move_up,
	output logic       move_down,
	output logic       move_left,
	output logic       move_right,
	output logic       fire,
	output logic       bomb,
	output logic       coin,
	output logic       start1,
	output logic       start2
);

	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic up_c;
	logic down_c;
	logic left_c;
	logic right_c;

	assign src_up    = held_keys.up | joy0.up | joy1.up;
	assign src_down  = held_keys.down | joy0.down | joy1.down;
	assign src_left  = held_keys.left | joy0.left | joy1.left;
	assign src_right = held_keys.right | joy0.right | joy1.right;

	// low means the monitor is on its side
	always_comb begin
		if (rotate_controls) begin
			up_c    = src_up;
			down_c  = src_down;
			left_c  = src_left;
			right_c = src_right;
		end else begin
			up_c    = src_left;
			down_c  = src_right;
			left_c  = src_down;
			right_c = src_up;
		end
	end

	always_ff @(posedge clk_36) begin
		if (rst) begin
			move_up    <= 1'b0;
			move_down  <= 1'b0;
			move_left  <= 1'b0;
			move_right <= 1'b0;
			fire       <= 1'b0;
			bomb       <= 1'b0;
			coin       <= 1'b0;
			start1     <= 1'b0;
			start2     <= 1'b0;
		end else begin
			move_up    <= up_c;
			move_down  <= down_c;
			move_left  <= left_c;
			move_right <= right_c;
			fire       <= held_keys.fire1 | joy0.fire | joy1.fire;
			bomb       <= held_keys.fire2 | joy0.bomb | joy1.bomb;
			coin       <= held_keys.coin; // keyboard only
			start1     <= held_keys.start1;
			start2     <= held_keys.start2;
		end
	end

endmodule

/* video/pixel_stage.sv */
`timescale 1ns/1ps
`include "cab_defs.svh"

module pixel_stage import video_pkg::*; (
	input  logic       clk_36,
	input  logic       rst,
	input  logic       pix_ce,
	input  core_rgb_t  core_rgb,
	input  logic       hblank,
	input  logic       vblank,
	input  logic       hsync,
	input  logic       vsync,
	input  scan_mode_t scanline_mode,
	output vga_color_t vga_r,
	output vga_color_t vga_g,
	output vga_color_t vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	localparam int rg_pad = `VGA_W - `CORE_RG_W;
	localparam int b_pad = `VGA_W - `CORE_B_W;

	logic       hsync_q;
	logic       line_odd;
	logic       blank;
	vga_color_t r_exp;
	vga_color_t g_exp;
	vga_color_t b_exp;

	function automatic vga_color_t dim(input vga_color_t v, input scan_mode_t mode);
		case (mode)
			scan_dim25: return v - (v >> 2);
			scan_dim50: return v >> 1;
			scan_dim75: return v >> 2;
			default: return v;
		endcase
	endfunction

	assign blank = hblank | vblank;

	// pad with 0..01 so full scale lands just under the top code
	assign r_exp = blank ? '0 : {core_rgb.r, {(rg_pad - 1){1'b0}}, 1'b1};
	assign g_exp = blank ? '0 : {core_rgb.g, {(rg_pad - 1){1'b0}}, 1'b1};
	assign b_exp = blank ? '0 : {core_rgb.b, {(b_pad - 1){1'b0}}, 1'b1};

	always_ff @(posedge clk_36) begin
		if (rst) begin
			hsync_q  <= 1'b0;
			line_odd <= 1'b0;
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
		end else if (pix_ce) begin
			hsync_q <= hsync;
			if (vsync)
				line_odd <= 1'b0; // restart parity each frame
			else if (hsync && !hsync_q)
				line_odd <= !line_odd;
			vga_r  <= line_odd ? dim(r_exp, scanline_mode) : r_exp;
			vga_g  <= line_odd ? dim(g_exp, scanline_mode) : g_exp;
			vga_b  <= line_odd ? dim(b_exp, scanline_mode) : b_exp;
			vga_hs <= hsync;
			vga_vs <= vsync;
		end
	end

endmodule

/* src/audio_dac.sv */
`timescale 1ns/1ps
`include "cab_defs.svh"

module audio_dac #(
	parameter int width = `DAC_WIDTH
) (
	input  logic             clk_36,
	input  logic             rst,
	input  logic [width-1:0] sample,
	output logic             audio_out
);

	logic [width-1:0] acc;
	logic [width:0]   sum;

	// first order, the carry out is the pulse density
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_36) begin
		if (rst) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= sum[width-1:0];
			audio_out <= sum[width];
		end
	end

endmodule

/* src/cabinet_io.sv */
`timescale 1ns/1ps
`include "cab_defs.svh"

module cabinet_io import ctrl_pkg::*, video_pkg::*; (
	input  logic                  clk_36,
	input  logic                  rst,
	input  logic                  key_toggle,
	input  logic                  key_pressed,
	input  logic [7:0]            key_code,
	input  joy_t                  joy0,
	input  joy_t                  joy1,
	input  logic                  rotate_controls,
	input  logic                  pix_ce,
	input  core_rgb_t             core_rgb,
	input  logic                  hblank,
	input  logic                  vblank,
	input  logic                  hsync,
	input  logic                  vsync,
	input  scan_mode_t            scanline_mode,
	input  logic [`DAC_WIDTH-1:0] audio_sample,
	output logic                  move_up,
	output logic                  move_down,
	output logic                  move_left,
	output logic                  move_right,
	output logic                  fire,
	output logic                  bomb,
	output logic                  coin,
	output logic                  start1,
	output logic                  start2,
	output vga_color_t            vga_r,
	output vga_color_t            vga_g,
	output vga_color_t            vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  audio_out
);

	held_keys_t held_keys;

	key_mapper key_mapper_i (
		.clk_36      (clk_36),
		.rst         (rst),
		.key_toggle  (key_toggle),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.held_keys   (held_keys)
	);

	control_router control_router_i (
		.clk_36          (clk_36),
		.rst             (rst),
		.held_keys       (held_keys),
		.joy0            (joy0),
		.joy1            (joy1),
		.rotate_controls (rotate_controls),
		.move_up         (move_up),
		.move_down       (move_down),
		.move_left       (move_left),
		.move_right      (move_right),
		.fire            (fire),
		.bomb            (bomb),
		.coin            (coin),
		.start1          (start1),
		.start2          (start2)
	);

	pixel_stage pixel_stage_i (
		.clk_36        (clk_36),
		.rst           (rst),
		.pix_ce        (pix_ce),
		.core_rgb      (core_rgb),
		.hblank        (hblank),
		.vblank        (vblank),
		.hsync         (hsync),
		.vsync         (vsync),
		.scanline_mode (scanline_mode),
		.vga_r         (vga_r),
		.vga_g         (vga_g),
		.vga_b         (vga_b),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs)
	);

	audio_dac #(
		.width (`DAC_WIDTH)
	) audio_dac_i (
		.clk_36    (clk_36),
		.rst       (rst),
		.sample    (audio_sample),
		.audio_out (audio_out)
	);

endmodule

/* tests/cabinet_props.sv */
`timescale 1ns/1ps
`include "cab_defs.svh"

module cabinet_props (
	input logic               clk_36,
	input logic               rst,
	input logic               pix_ce,
	input logic               hblank,
	input logic               vblank,
	input logic               hsync,
	input logic               vsync,
	input logic [`VGA_W-1:0]  vga_r,
	input logic [`VGA_W-1:0]  vga_g,
	input logic [`VGA_W-1:0]  vga_b,
	input logic               vga_hs,
	input logic               vga_vs,
	input logic               audio_out,
	input logic               move_up,
	input logic               fire
);

	reset_clears: assert property (@(posedge clk_36)
		rst |=> (vga_r == 0 && vga_hs == 0 && !audio_out && !move_up && !fire))
		else $error("outputs not cleared by reset");

	blank_gives_black: assert property (@(posedge clk_36) disable iff (rst)
		pix_ce && (hblank || vblank) |=> (vga_r == 0 && vga_g == 0 && vga_b == 0))
		else $error("blanked pixel is not black");

	sync_one_strobe: assert property (@(posedge clk_36) disable iff (rst)
		pix_ce |=> (vga_hs == $past(hsync) && vga_vs == $past(vsync)))
		else $error("syncs not delayed by one strobe");

	hold_between_strobes: assert property (@(posedge clk_36) disable iff (rst)
		!pix_ce |=> ($stable(vga_r) && $stable(vga_hs)))
		else $error("video output moved without a strobe");

endmodule

/* tests/cabinet_checker.sv */
`timescale 1ns/1ps

module cabinet_checker import ctrl_pkg::*, video_pkg::*; (
	input  logic       clk_36,
	input  logic       rst,
	input  logic       pix_ce,
	input  core_rgb_t  core_rgb,
	input  logic       hblank,
	input  logic       vblank,
	input  logic       hsync,
	input  logic       vsync,
	input  scan_mode_t scanline_mode,
	input  logic [8:0] ctrl,
	input  logic [5:0] vga_r,
	input  logic [5:0] vga_g,
	input  logic [5:0] vga_b,
	input  logic       vga_hs,
	input  logic       vga_vs,
	input  logic       audio_out,
	input  logic       req,
	input  int         req_test,
	input  logic [7:0] req_kind,
	input  logic [9:0] req_exp,
	input  logic       count_en,
	input  logic       all_done,
	output logic       finished,
	output int         failed_tests
);

	int         cur_test = 1; // test 1 is the reset check
	int         test_errs = 0;
	int         run_tests = 0;
	int         ones = 0;
	logic       rst_q = 1'b0;
	logic       parity = 1'b0;
	logic       hs_q = 1'b0;
	logic [5:0] exp_r;
	logic [5:0] exp_g;
	logic [5:0] exp_b;
	logic       exp_hs;
	logic       exp_vs;

	initial begin
		finished = 1'b0;
		failed_tests = 0;
	end

	function automatic logic [5:0] scan_dim(input logic [5:0] v, input scan_mode_t mode);
		case (mode)
			scan_dim25: return v - v / 6'd4;
			scan_dim50: return v / 6'd2;
			scan_dim75: return v / 6'd4;
			default: return v;
		endcase
	endfunction

	task automatic report_err(input string msg);
		$display("ERR %0t: %s", $time, msg);
		test_errs++;
	endtask

	task automatic close_test();
		run_tests++;
		if (test_errs == 0) begin
			$display("test %0d passed", cur_test);
		end else begin
			$display("test %0d failed with %0d errors", cur_test, test_errs);
			failed_tests++;
		end
		test_errs = 0;
	endtask

	always @(negedge clk_36) begin
		if (rst_q && ({ctrl, vga_r, vga_g, vga_b, vga_hs, vga_vs, audio_out} !== '0))
			report_err("outputs not low during or just after reset");
		rst_q = rst;
		if (rst) begin
			parity = 1'b0;
			hs_q = 1'b0;
		end
		if (count_en)
			ones = ones + int'(audio_out);
		if (req) begin
			if (req_test != cur_test) begin
				close_test();
				cur_test = req_test;
			end
			case (req_kind)
				"K", "J": begin
					if (ctrl !== req_exp[8:0])
						report_err($sformatf("controls %03h, expected %03h", ctrl, req_exp[8:0]));
				end
				"P": begin
					if ({vga_r, vga_g, vga_b, vga_hs, vga_vs} !==
							{exp_r, exp_g, exp_b, exp_hs, exp_vs})
						report_err($sformatf("pixel %h %h %h %b%b, expected %h %h %h %b%b",
							vga_r, vga_g, vga_b, vga_hs, vga_vs,
							exp_r, exp_g, exp_b, exp_hs, exp_vs));
				end
				"A": begin
					if (ones != int'(req_exp))
						report_err($sformatf("audio ones %0d, expected %0d", ones, req_exp));
					ones = 0;
				end
				default: report_err("unknown record kind in data file");
			endcase
		end
		if (pix_ce && !rst) begin
			// result shows up one strobe later
			exp_r = (hblank || vblank) ? 6'd0 : {core_rgb.r, 3'b001};
			exp_g = (hblank || vblank) ? 6'd0 : {core_rgb.g, 3'b001};
			exp_b = (hblank || vblank) ? 6'd0 : {core_rgb.b, 4'b0001};
			if (parity) begin
				exp_r = scan_dim(exp_r, scanline_mode);
				exp_g = scan_dim(exp_g, scanline_mode);
				exp_b = scan_dim(exp_b, scanline_mode);
			end
			exp_hs = hsync;
			exp_vs = vsync;
			if (vsync)
				parity = 1'b0;
			else if (hsync && !hs_q)
				parity = !parity;
			hs_q = hsync;
		end
		if (all_done && !finished) begin
			close_test();
			$display("tests run %0d, passed %0d, failed %0d", run_tests,
				run_tests - failed_tests, failed_tests);
			finished = 1'b1;
		end
	end

endmodule

/* tests/tb_cabinet_io.sv */
`timescale 1ns/1ps
`include "cab_defs.svh"

module tb_cabinet_io import ctrl_pkg::*, video_pkg::*; ();

	logic                  clk_36 = 1'b0;
	logic                  rst;
	logic                  key_toggle;
	logic                  key_pressed;
	logic                  rotate_controls;
	logic                  pix_ce;
	logic [7:0]            key_code;
	joy_t                  joy0;
	joy_t                  joy1;
	core_rgb_t             core_rgb;
	logic                  hblank;
	logic                  vblank;
	logic                  hsync;
	logic                  vsync;
	scan_mode_t            scanline_mode;
	logic [`DAC_WIDTH-1:0] audio_sample;
	logic                  move_up;
	logic                  move_down;
	logic                  move_left;
	logic                  move_right;
	logic                  fire;
	logic                  bomb;
	logic                  coin;
	logic                  start1;
	logic                  start2;
	logic                  vga_hs;
	logic                  vga_vs;
	logic                  audio_out;
	vga_color_t            vga_r;
	vga_color_t            vga_g;
	vga_color_t            vga_b;
	logic                  req;
	logic                  count_en;
	logic                  all_done;
	logic                  finished;
	int                    req_test;
	int                    failed_tests;
	logic [7:0]            req_kind;
	logic [9:0]            req_exp;
	int                    cycles = 0;
	int                    limit = 0;
	int                    rec_test[$];
	logic [7:0]            rec_kind[$];
	logic [9:0]            rec_a[$];
	logic [9:0]            rec_b[$];
	logic [9:0]            rec_c[$];
	logic [9:0]            rec_e[$];

	cabinet_io cabinet_io_i (.*);

	cabinet_checker checker_i (.*, .ctrl({move_up, move_down, move_left, move_right,
		fire, bomb, coin, start1, start2}));

	bind cabinet_io cabinet_props props_i (
		.clk_36(clk_36), .rst(rst), .pix_ce(pix_ce), .hblank(hblank), .vblank(vblank),
		.hsync(hsync), .vsync(vsync), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .audio_out(audio_out), .move_up(move_up),
		.fire(fire)
	);

	always #2 clk_36 = ~clk_36;

	always @(posedge clk_36) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, the checker never finished", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic wait_edges(input int n);
		repeat (n) @(posedge clk_36);
		#1;
	endtask

	task automatic request_check(input int t, input logic [7:0] k, input logic [9:0] e);
		req_test = t;
		req_kind = k;
		req_exp = e;
		req = 1'b1;
		wait_edges(1);
		req = 1'b0;
	endtask

	initial begin
		int fd;
		int n;
		int seed;
		int rnd;
		int audio_recs;
		int t;
		reg [8*96-1:0] line;
		reg [7:0] k;
		reg [9:0] a;
		reg [9:0] b;
		reg [9:0] c;
		reg [9:0] e;
		seed = 36417;
		audio_recs = 0;
		rst = 1'b1;
		key_toggle = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		rotate_controls = 1'b0;
		pix_ce = 1'b0;
		joy0 = '0;
		joy1 = '0;
		core_rgb = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		scanline_mode = scan_off;
		audio_sample = '0;
		req = 1'b0;
		count_en = 1'b0;
		all_done = 1'b0;
		req_test = 0;
		req_kind = '0;
		req_exp = '0;
		fd = $fopen("tests/cabinet_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/cabinet_testdata.txt");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				n = $fgets(line, fd);
				if (n != 0 && $sscanf(line, "%d %s %h %h %h %h", t, k, a, b, c, e) == 6) begin
					rec_test.push_back(t);
					rec_kind.push_back(k);
					rec_a.push_back(a);
					rec_b.push_back(b);
					rec_c.push_back(c);
					rec_e.push_back(e);
					if (k == "A")
						audio_recs++;
				end
			end
			$fclose(fd);
			limit = rec_test.size() * 8 + 2200 * audio_recs + 100;
			wait_edges(16);
			rst = 1'b0;
			for (int i = 0; i < rec_test.size(); i++) begin
				rnd = $random(seed);
				case (rec_kind[i])
					"K": begin
						joy0 = joy_t'(rnd[7:0] & 8'hc0); // unused bits only
						joy1 = joy_t'(rnd[15:8] & 8'hc0);
						rotate_controls = rec_c[i][0];
						key_pressed = rec_a[i][0];
						key_code = rec_b[i][7:0];
						key_toggle = ~key_toggle;
						wait_edges(2);
					end
					"J": begin
						joy0 = joy_t'(rec_a[i][7:0] | (rnd[7:0] & 8'hc0));
						joy1 = joy_t'(rec_b[i][7:0] | (rnd[15:8] & 8'hc0));
						rotate_controls = rec_c[i][0];
						wait_edges(1);
					end
					"P": begin
						core_rgb = core_rgb_t'(rec_a[i][7:0]);
						{hblank, vblank, hsync, vsync} = rec_b[i][3:0];
						scanline_mode = scan_mode_t'(rec_c[i][1:0]);
						pix_ce = 1'b1;
						wait_edges(1);
						pix_ce = 1'b0;
					end
					default: begin
						audio_sample = rec_a[i];
						rst = 1'b1;
						wait_edges(2);
						rst = 1'b0;
						wait_edges(1);
						count_en = 1'b1; // window starts on the first bit after reset
						wait_edges(1024);
						count_en = 1'b0;
					end
				endcase
				request_check(rec_test[i], rec_kind[i], rec_e[i]);
			end
			all_done = 1'b1;
			wait (finished);
			if (failed_tests == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

/* tests/cabinet_testdata.txt */
# test kind a b c expected (hex). K: pressed code rotate controls. J: joy0 joy1 rotate controls
# P: rgb {hblank,vblank,hsync,vsync} mode 0. A: sample 0 0 ones. controls = up,dn,lt,rt,fi,bo,co,s1,s2
2 K 1 75 1 100
2 K 1 6b 1 140
2 K 0 75 1 040
2 K 1 72 1 0c0
2 K 1 1c 1 0c0
2 K 0 6b 1 080
2 K 1 74 1 0a0
2 K 1 76 1 0a4
2 K 1 05 1 0a6
2 K 1 06 1 0a7
2 K 1 29 1 0b7
2 K 1 11 1 0bf
2 K 1 14 1 0bf
2 K 0 72 1 03f
3 J 00 00 0 09f
3 J 08 00 0 0bf
3 J 00 04 0 0df
3 J 00 02 1 07f
3 J 20 10 1 03f
4 P e5 0 0 0
4 P ff 8 0 0
4 P 24 2 0 0
5 P ff 0 1 0
5 P ff 2 2 0
5 P 00 0 3 0
5 P b6 2 3 0
5 P b6 0 3 0
5 P 49 1 1 0
6 A 000 0 0 000
6 A 001 0 0 001
6 A 200 0 0 200
6 A 3ff 0 0 3ff

/* all.f */
+incdir+common
common/ctrl_pkg.sv
common/video_pkg.sv
input/key_mapper.sv
input/control_router.sv
video/pixel_stage.sv
src/audio_dac.sv
src/cabinet_io.sv
tests/cabinet_props.sv
tests/cabinet_checker.sv
tests/tb_cabinet_io.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root, result is taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_cabinet_io -o sim_cabinet \
	&& ./obj_dir/sim_cabinet > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "STATUS: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
